// File: ialu.sv
//------------------------------
// Integer ALU top level
// Core and divider run in parallel, selector picks the result
// Hold command and operands until res_rdy_o is high at an edge
//------------------------------

`timescale 1ns/100ps
`default_nettype none

module ialu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cmd_vd_i,    // Command valid
    input  ialu_pkg::ialu_cmd_e  cmd_i,       // ALU command
    input  ialu_pkg::ialu_word_t op1_i,       // First operand
    input  ialu_pkg::ialu_word_t op2_i,       // Second operand
    output ialu_pkg::ialu_word_t res_o,       // Result
    output logic                 cmp_o,       // Compare bit
    output logic                 res_rdy_o    // Result ready
);

    import ialu_pkg::*;

    ialu_core_res_s core_res;   // Core data and flags
    ialu_div_res_s  div_res;    // Divider result and ready

    // Single-cycle ops
    ialu_arith_logic u_arith_logic (
        .cmd_i      (cmd_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .core_res_o (core_res)
    );

    // Multi-cycle division
    ialu_divider u_divider (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_vd_i   (cmd_vd_i),
        .cmd_i      (cmd_i),
        .op1_i      (op1_i),
        .op2_i      (op2_i),
        .div_res_o  (div_res)
    );

    ialu_result_sel u_result_sel (
        .cmd_i      (cmd_i),
        .core_res_i (core_res),
        .div_res_i  (div_res),
        .res_o      (res_o),
        .cmp_o      (cmp_o),
        .res_rdy_o  (res_rdy_o)
    );

endmodule

`default_nettype wire

// File: ialu_arith_logic.sv
//------------------------------
// Combinational ALU core
// Main adder with compare flags, bitwise ops and barrel shifter
// Compare decoding happens later in the result selector
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "ialu_macros.svh"

module ialu_arith_logic (
    input  ialu_pkg::ialu_cmd_e      cmd_i,       // ALU command
    input  ialu_pkg::ialu_word_t     op1_i,       // First operand
    input  ialu_pkg::ialu_word_t     op2_i,       // Second operand
    output ialu_pkg::ialu_core_res_s core_res_o   // Data word and flags
);

    import ialu_pkg::*;

    logic [`IALU_XLEN:0] sum;           // Extra MSB holds the carry
    logic                pos_ovflw;     // Pos minus neg gave negative
    logic                neg_ovflw;     // Neg minus pos gave positive
    ialu_shamt_t         shamt;         // Shift amount

    //------------------------------
    // Main adder
    //------------------------------

    // Subtract for everything but ADD, compares need the difference
    always_comb begin
        if (cmd_i == IALU_CMD_ADD) begin
            sum = {1'b0, op1_i} + {1'b0, op2_i};
        end else begin
            sum = {1'b0, op1_i} - {1'b0, op2_i};
        end
    end

    assign pos_ovflw = ~op1_i[`IALU_XLEN-1] &  op2_i[`IALU_XLEN-1] &  sum[`IALU_XLEN-1];
    assign neg_ovflw =  op1_i[`IALU_XLEN-1] & ~op2_i[`IALU_XLEN-1] & ~sum[`IALU_XLEN-1];

    assign core_res_o.flags.c = sum[`IALU_XLEN];
    assign core_res_o.flags.z = ~|sum[`IALU_XLEN-1:0];
    assign core_res_o.flags.s = sum[`IALU_XLEN-1];
    assign core_res_o.flags.o = pos_ovflw | neg_ovflw;

    //------------------------------
    // Logic ops and shifter
    //------------------------------

    assign shamt = op2_i[`IALU_SHAMT_W-1:0];   // Only low bits count

    always_comb begin
        case (cmd_i)
            IALU_CMD_AND : core_res_o.data = op1_i & op2_i;
            IALU_CMD_OR  : core_res_o.data = op1_i | op2_i;
            IALU_CMD_XOR : core_res_o.data = op1_i ^ op2_i;
            IALU_CMD_ADD,
            IALU_CMD_SUB : core_res_o.data = sum[`IALU_XLEN-1:0];
            IALU_CMD_SLL : core_res_o.data = op1_i << shamt;
            IALU_CMD_SRL : core_res_o.data = op1_i >> shamt;
            // Arithmetic shift keeps the sign bit
            IALU_CMD_SRA : core_res_o.data = ialu_word_t'($signed(op1_i) >>> shamt);
            default      : core_res_o.data = '0;   // Compares and divides elsewhere
        endcase
    end

endmodule

`default_nettype wire

// File: ialu_divider.sv
//------------------------------
// Iterative non-restoring divider for DIV, DIVU, REM and REMU
// One quotient bit per cycle, optional sign correction cycle
// Zero operands finish in the first cycle
//------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "ialu_macros.svh"

module ialu_divider (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cmd_vd_i,    // Command valid
    input  ialu_pkg::ialu_cmd_e     cmd_i,       // ALU command
    input  ialu_pkg::ialu_word_t    op1_i,       // Dividend
    input  ialu_pkg::ialu_word_t    op2_i,       // Divisor
    output ialu_pkg::ialu_div_res_s div_res_o    // Ownership, ready and result
);

    import ialu_pkg::*;

    // Command decode
    logic              cmd_div;         // Any division command
    logic              cmd_rem;         // REM or REMU
    logic              cmd_sgn;         // DIV or REM
    logic              op1_neg;         // Signed and dividend negative
    logic              op2_neg;         // Signed and divisor negative
    logic              ops_non_zero;
    logic              ops_diff_sgn;

    // FSM control
    ialu_div_fsm_e     fsm_ff;
    ialu_div_fsm_e     fsm_next;
    logic              fsm_idle;
    logic              fsm_corr;
    logic              iter_req;        // Start iterating from IDLE
    logic              iter_rdy;        // Last iteration
    logic              corr_req;        // Extra correction cycle needed
    logic              upd;             // Datapath registers advance

    logic [`IALU_XLEN-1:0] iter_cnt;    // One-hot, shifts right

    // Datapath
    logic                  sum_sub;
    logic [`IALU_XLEN:0]   sum_op1;
    logic [`IALU_XLEN:0]   sum_op2;
    logic [`IALU_XLEN:0]   sum_res;
    logic                  rem_c;       // Sign of partial remainder
    ialu_word_t            rem;
    ialu_word_t            quo;
    logic                  quo_bit;
    ialu_word_t            dvdnd_lo_ff; // Dividend bits still to shift in
    ialu_word_t            dvdnd_lo_next;
    logic                  res_c_ff;
    ialu_word_t            res_hi_ff;   // Partial remainder
    ialu_word_t            res_lo_ff;   // Partial quotient

    //------------------------------
    // Decode
    //------------------------------

    assign cmd_div = (cmd_i == IALU_CMD_DIV) | (cmd_i == IALU_CMD_DIVU)
                   | (cmd_i == IALU_CMD_REM) | (cmd_i == IALU_CMD_REMU);
    assign cmd_rem = (cmd_i == IALU_CMD_REM) | (cmd_i == IALU_CMD_REMU);
    assign cmd_sgn = (cmd_i == IALU_CMD_DIV) | (cmd_i == IALU_CMD_REM);

    assign op1_neg      = cmd_sgn & op1_i[`IALU_XLEN-1];
    assign op2_neg      = cmd_sgn & op2_i[`IALU_XLEN-1];
    assign ops_non_zero = |op1_i & |op2_i;
    assign ops_diff_sgn = op1_i[`IALU_XLEN-1] ^ op2_i[`IALU_XLEN-1];

    assign iter_req = cmd_div & ops_non_zero & fsm_idle;
    assign iter_rdy = iter_cnt[0];

    // Negate quotient for DIV with mixed signs, or fix remainder sign
    assign corr_req = cmd_div
                    & ((cmd_i == IALU_CMD_DIV) & ops_diff_sgn
                      | cmd_rem & |rem & (op1_neg ^ rem_c));

    assign upd = cmd_vd_i & ~div_res_o.rdy;

    //------------------------------
    // FSM and counter
    //------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (~rst_n) begin
            fsm_ff   <= IALU_DIV_IDLE;
            iter_cnt <= '0;
        end else begin
            fsm_ff <= fsm_next;
            if (upd) begin
                iter_cnt <= ~fsm_idle ? iter_cnt >> 1
                          : cmd_div   ? `IALU_DIV_CNT_INIT
                                      : iter_cnt;
            end
        end
    end

    // Dropping valid abandons the operation
    always_comb begin
        fsm_next = IALU_DIV_IDLE;
        if (cmd_vd_i) begin
            case (fsm_ff)
                IALU_DIV_IDLE : fsm_next = iter_req ? IALU_DIV_ITER : IALU_DIV_IDLE;
                IALU_DIV_ITER : fsm_next = ~iter_rdy ? IALU_DIV_ITER
                                         : corr_req  ? IALU_DIV_CORR
                                                     : IALU_DIV_IDLE;
                default       : fsm_next = IALU_DIV_IDLE;
            endcase
        end
    end

    assign fsm_idle = (fsm_ff == IALU_DIV_IDLE);
    assign fsm_corr = (fsm_ff == IALU_DIV_CORR);

    //------------------------------
    // Adder and quotient bit
    //------------------------------

    always_comb begin
        sum_sub = 1'b0;
        sum_op1 = '0;
        sum_op2 = '0;
        if (cmd_div) begin
            // Subtract when remainder and divisor signs agree, else add
            sum_sub = ~(cmd_sgn & ops_diff_sgn)
                    ^ (fsm_corr ? op1_neg ^ res_c_ff
                     : fsm_idle ? 1'b0
                                : ~res_lo_ff[0]);
            sum_op1 = fsm_corr ? {1'b0, res_hi_ff}
                    : fsm_idle ? {{`IALU_XLEN{op1_neg}}, op1_i[`IALU_XLEN-1]}
                               : {res_hi_ff, dvdnd_lo_ff[`IALU_XLEN-1]};
            sum_op2 = {op2_neg, op2_i};
        end
        sum_res = sum_sub ? sum_op1 - sum_op2 : sum_op1 + sum_op2;
    end

    always_comb begin
        rem_c   = 1'b0;
        rem     = '0;
        quo     = '0;
        quo_bit = 1'b0;
        if (cmd_div & ~fsm_corr) begin
            rem_c   = sum_res[`IALU_XLEN];
            rem     = sum_res[`IALU_XLEN-1:0];
            // Negative dividend hitting exactly zero also sets the bit
            quo_bit = ~(op1_neg ^ rem_c)
                    | (op1_neg & ({sum_res, dvdnd_lo_next} == '0));
            quo     = fsm_idle ? ialu_word_t'(quo_bit)
                               : {res_lo_ff[`IALU_XLEN-2:0], quo_bit};
        end
    end

    assign dvdnd_lo_next = (~cmd_div | fsm_corr) ? '0
                         : fsm_idle              ? op1_i << 1
                                                 : dvdnd_lo_ff << 1;

    //------------------------------
    // Intermediate registers
    //------------------------------

    always_ff @(posedge clk) begin
        if (upd & cmd_div) begin
            dvdnd_lo_ff <= dvdnd_lo_next;
            res_c_ff    <= rem_c;
            res_hi_ff   <= rem;
            res_lo_ff   <= quo;
        end
    end

    //------------------------------
    // Result
    //------------------------------

    assign div_res_o.owns = cmd_div;

    always_comb begin
        case (fsm_ff)
            IALU_DIV_ITER : begin
                div_res_o.res = cmd_rem ? rem : quo;
                div_res_o.rdy = iter_rdy & ~corr_req;
            end
            IALU_DIV_CORR : begin
                div_res_o.res = cmd_rem ? sum_res[`IALU_XLEN-1:0] : -res_lo_ff;
                div_res_o.rdy = 1'b1;
            end
            default : begin
                // Zero operand shortcut, divide by zero gives all ones
                div_res_o.res = (|op2_i | cmd_rem) ? op1_i : '1;
                div_res_o.rdy = ~iter_req;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: ialu_macros.svh
//------------------------------
// Width and sequencing constants for the integer ALU
// Included by the package and by any module that sizes vectors
//------------------------------

`ifndef IALU_MACROS_SVH
`define IALU_MACROS_SVH

// Data word width
`define IALU_XLEN           32

// Shift amount width, log2 of the word width
`define IALU_SHAMT_W        5

// One-hot divider counter start, bit 30 gives 31 ITER cycles
`define IALU_DIV_CNT_INIT   32'h4000_0000

`endif

// File: ialu_pkg.sv
//------------------------------
// Shared types for the integer ALU
// Word types, command and divider state enums, result structs
//------------------------------

`default_nettype none

`include "ialu_macros.svh"

package ialu_pkg;

    typedef logic [`IALU_XLEN-1:0]    ialu_word_t;   // Operand or result word
    typedef logic [`IALU_SHAMT_W-1:0] ialu_shamt_t;  // Shift amount

    // ALU command
    typedef enum logic [4:0] {
        IALU_CMD_NONE,
        IALU_CMD_AND,
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_ADD,
        IALU_CMD_SUB,
        IALU_CMD_SUB_LT,
        IALU_CMD_SUB_LTU,
        IALU_CMD_SUB_EQ,
        IALU_CMD_SUB_NE,
        IALU_CMD_SUB_GE,
        IALU_CMD_SUB_GEU,
        IALU_CMD_SLL,
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_DIV,
        IALU_CMD_DIVU,
        IALU_CMD_REM,
        IALU_CMD_REMU
    } ialu_cmd_e;

    // Flags of the main subtraction
    typedef struct packed {
        logic z;    // Zero
        logic s;    // Sign
        logic o;    // Signed overflow
        logic c;    // Carry out, i.e. unsigned borrow
    } ialu_flags_s;

    // Combinational core output
    typedef struct packed {
        ialu_word_t  data;
        ialu_flags_s flags;
    } ialu_core_res_s;

    // Divider output
    typedef struct packed {
        logic       owns;   // Command belongs to the divider
        logic       rdy;    // Result valid this cycle
        ialu_word_t res;    // Quotient or remainder
    } ialu_div_res_s;

    // Divider FSM states
    typedef enum logic [1:0] {
        IALU_DIV_IDLE,
        IALU_DIV_ITER,
        IALU_DIV_CORR
    } ialu_div_fsm_e;

endpackage

`default_nettype wire

// File: ialu_result_sel.sv
//------------------------------
// Result selector for the integer ALU
// Decodes compare flags and muxes core and divider outputs
//------------------------------

`timescale 1ns/100ps
`default_nettype none

module ialu_result_sel (
    input  ialu_pkg::ialu_cmd_e      cmd_i,        // ALU command
    input  ialu_pkg::ialu_core_res_s core_res_i,   // From combinational core
    input  ialu_pkg::ialu_div_res_s  div_res_i,    // From divider
    output ialu_pkg::ialu_word_t     res_o,        // Final result
    output logic                     cmp_o,        // Compare bit
    output logic                     res_rdy_o     // Result ready
);

    import ialu_pkg::*;

    logic lt;           // Signed less-than
    logic is_cmp;       // Command is a compare

    assign lt = core_res_i.flags.s ^ core_res_i.flags.o;

    //------------------------------
    // Compare decode
    //------------------------------

    always_comb begin
        is_cmp = 1'b1;
        case (cmd_i)
            IALU_CMD_SUB_LT  : cmp_o = lt;
            IALU_CMD_SUB_LTU : cmp_o = core_res_i.flags.c;
            IALU_CMD_SUB_EQ  : cmp_o = core_res_i.flags.z;
            IALU_CMD_SUB_NE  : cmp_o = ~core_res_i.flags.z;
            IALU_CMD_SUB_GE  : cmp_o = ~lt;
            IALU_CMD_SUB_GEU : cmp_o = ~core_res_i.flags.c;
            default : begin
                is_cmp = 1'b0;
                cmp_o  = 1'b0;     // Low for non-compare commands
            end
        endcase
    end

    //------------------------------
    // Output mux
    //------------------------------

    always_comb begin
        if (div_res_i.owns) begin
            res_o     = div_res_i.res;     // Divider drives ready
            res_rdy_o = div_res_i.rdy;
        end else if (is_cmp) begin
            res_o     = ialu_word_t'(cmp_o);   // Zero-extended bit
            res_rdy_o = 1'b1;
        end else begin
            res_o     = core_res_i.data;
            res_rdy_o = 1'b1;              // Single-cycle ops always ready
        end
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
ialu_pkg.sv
ialu_arith_logic.sv
ialu_divider.sv
ialu_result_sel.sv
ialu.sv
tb_ialu.sv

// File: tb_ialu.sv
//------------------------------
// Self-checking testbench for the integer ALU
// Random and corner operands against a reference model
// Checks ready timing of the divider and abort on valid drop
//------------------------------

`timescale 1ns/100ps
`default_nettype none

module tb_ialu;

    import ialu_pkg::*;

    localparam int WAIT_MAX = 40;    // Cycles before a wait gives up
    localparam int DRIVE_DLY = 1;    // Input delay after the rising edge

    logic       clk;
    logic       rst_n;
    logic       cmd_vd;
    ialu_cmd_e  cmd;
    ialu_word_t op1;
    ialu_word_t op2;
    ialu_word_t res;
    logic       cmp;
    logic       res_rdy;
    logic       div_cmd;             // Current command is a division
    logic       cmp_cmd;             // Current command is a compare

    int         err_cnt = 0;
    int         seed = 32'h8953;
    ialu_word_t corner_vals [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

    ialu_cmd_e  single_cmds [8] = '{IALU_CMD_AND, IALU_CMD_OR, IALU_CMD_XOR, IALU_CMD_ADD,
                                    IALU_CMD_SUB, IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA};
    ialu_cmd_e  div_cmds [4] = '{IALU_CMD_DIV, IALU_CMD_DIVU, IALU_CMD_REM, IALU_CMD_REMU};

    ialu ialu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_vd_i  (cmd_vd),
        .cmd_i     (cmd),
        .op1_i     (op1),
        .op2_i     (op2),
        .res_o     (res),
        .cmp_o     (cmp),
        .res_rdy_o (res_rdy)
    );

    always #5 clk = ~clk;            // 10 ns period

    //------------------------------
    // Reference model
    //------------------------------

    function automatic logic is_div(input ialu_cmd_e c);
        return (c == IALU_CMD_DIV) || (c == IALU_CMD_DIVU)
            || (c == IALU_CMD_REM) || (c == IALU_CMD_REMU);
    endfunction

    function automatic logic ref_cmp(input ialu_cmd_e c, input ialu_word_t a, input ialu_word_t b);
        case (c)
            IALU_CMD_SUB_LT  : return $signed(a) < $signed(b);
            IALU_CMD_SUB_LTU : return a < b;
            IALU_CMD_SUB_EQ  : return a == b;
            IALU_CMD_SUB_NE  : return a != b;
            IALU_CMD_SUB_GE  : return $signed(a) >= $signed(b);
            IALU_CMD_SUB_GEU : return a >= b;
            default          : return 1'b0;   // Low outside compares
        endcase
    endfunction

    function automatic ialu_word_t ref_result(input ialu_cmd_e c, input ialu_word_t a,
                                              input ialu_word_t b);
        logic ovf;                   // Signed min over minus one
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (c)
            IALU_CMD_AND  : return a & b;
            IALU_CMD_OR   : return a | b;
            IALU_CMD_XOR  : return a ^ b;
            IALU_CMD_ADD  : return a + b;
            IALU_CMD_SUB  : return a - b;
            IALU_CMD_SLL  : return a << b[4:0];
            IALU_CMD_SRL  : return a >> b[4:0];
            IALU_CMD_SRA  : return ialu_word_t'($signed(a) >>> b[4:0]);
            // RISC-V rules for zero divisor and overflow
            IALU_CMD_DIV  : return (b == 0) ? '1 : ovf ? a : ialu_word_t'($signed(a) / $signed(b));
            IALU_CMD_DIVU : return (b == 0) ? '1 : a / b;
            IALU_CMD_REM  : return (b == 0) ? a : ovf ? '0 : ialu_word_t'($signed(a) % $signed(b));
            IALU_CMD_REMU : return (b == 0) ? a : a % b;
            default       : return ialu_word_t'(ref_cmp(c, a, b));   // Compares and NONE
        endcase
    endfunction

    //------------------------------
    // Checks
    //------------------------------

    assign div_cmd = is_div(cmd);
    assign cmp_cmd = (cmd >= IALU_CMD_SUB_LT) && (cmd <= IALU_CMD_SUB_GEU);

    // Single-cycle commands never stall
    assert property (@(posedge clk) disable iff (!rst_n) !div_cmd |-> res_rdy)
        else begin
            err_cnt++;
            $display("** Error res_rdy_o: expected 1, got %h", $sampled(res_rdy));
        end

    // Compare bit only for compares
    assert property (@(posedge clk) disable iff (!rst_n) !cmp_cmd |-> !cmp)
        else begin
            err_cnt++;
            $display("** Error cmp_o: expected 0, got %h", $sampled(cmp));
        end

    task automatic check_word(input string name, input ialu_word_t exp, input ialu_word_t act);
        assert (act === exp) else begin
            err_cnt++;
            $display("** Error %s: expected %h, got %h (%s op1=%h op2=%h)",
                     name, exp, act, cmd.name(), op1, op2);
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    //------------------------------
    // Stimulus helpers
    //------------------------------

    function automatic ialu_word_t pick_operand();
        int sel;
        sel = $unsigned($random(seed)) % 16;
        if (sel < 5) begin
            return corner_vals[sel];     // Corner value now and then
        end
        return $random(seed);
    endfunction

    function automatic ialu_word_t pick_nonzero();
        ialu_word_t w;
        w = pick_operand();
        if (w == 0) begin
            w = $random(seed) | 32'h1;
        end
        return w;
    endfunction

    // Counts cycles until ready, sampling mid-cycle
    task automatic wait_ready(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!res_rdy) begin
            cycles++;
            if (cycles >= WAIT_MAX) begin
                $display("Timeout: res_rdy_o never came within %0d cycles for %s",
                         WAIT_MAX, cmd.name());
                err_cnt++;
                finish_run();
            end
            @(negedge clk);
        end
    endtask

    // One full handshake that returns just after the completing edge
    task automatic run_op(input ialu_cmd_e c, input ialu_word_t a, input ialu_word_t b);
        int cycles;
        cmd_vd = 1'b1;
        cmd    = c;
        op1    = a;
        op2    = b;
        wait_ready(cycles);
        check_word("res_o", ref_result(c, a, b), res);
        check_word("cmp_o", ialu_word_t'(ref_cmp(c, a, b)), ialu_word_t'(cmp));
        if (is_div(c) && (a != 0) && (b != 0)) begin
            if (c == IALU_CMD_DIVU) begin
                check_word("res_rdy_o cycle", 31, cycles);
            end
            assert (cycles <= 32) else begin
                err_cnt++;
                $display("Ready came in cycle %0d, later than cycle 32 for %s", cycles, c.name());
            end
        end else begin
            check_word("res_rdy_o cycle", 0, cycles);   // Same-cycle result
        end
        @(posedge clk);
        #DRIVE_DLY;
        cmd_vd = 1'b0;
        cmd    = IALU_CMD_NONE;
    endtask

    //------------------------------
    // Test sequence
    //------------------------------

    initial begin
        ialu_word_t a;
        clk    = 1'b0;
        rst_n  = 1'b0;
        cmd_vd = 1'b0;
        cmd    = IALU_CMD_NONE;
        op1    = '0;
        op2    = '0;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        @(negedge clk);
        check_word("res_rdy_o", 1, ialu_word_t'(res_rdy));   // Idle after reset
        @(posedge clk);
        #DRIVE_DLY;

        // Logic, add and shift
        foreach (single_cmds[i]) begin
            for (int n = 0; n < 20; n++) begin
                run_op(single_cmds[i], pick_operand(), pick_operand());
            end
        end

        // Compares over all corner pairs plus random and equal operands
        for (int c = IALU_CMD_SUB_LT; c <= IALU_CMD_SUB_GEU; c++) begin
            foreach (corner_vals[i]) begin
                foreach (corner_vals[j]) begin
                    run_op(ialu_cmd_e'(c), corner_vals[i], corner_vals[j]);
                end
            end
            for (int n = 0; n < 10; n++) begin
                a = pick_operand();
                run_op(ialu_cmd_e'(c), a, a);
                run_op(ialu_cmd_e'(c), pick_operand(), pick_operand());
            end
        end

        // Division on nonzero operands and RISC-V corners
        foreach (div_cmds[i]) begin
            for (int n = 0; n < 12; n++) begin
                run_op(div_cmds[i], pick_nonzero(), pick_nonzero());
            end
            run_op(div_cmds[i], pick_nonzero(), 32'h0);
            run_op(div_cmds[i], 32'h0, pick_nonzero());
            run_op(div_cmds[i], 32'h0, 32'h0);
            run_op(div_cmds[i], 32'h8000_0000, 32'hffff_ffff);
        end

        // Drop valid in the middle of a division
        cmd_vd = 1'b1;
        cmd    = IALU_CMD_DIV;
        op1    = 32'h8765_4321;
        op2    = 32'h0000_0123;
        repeat (10) @(posedge clk);
        #DRIVE_DLY;
        cmd_vd = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        run_op(IALU_CMD_DIV, 32'hfedc_ba98, 32'h0000_0777);
        run_op(IALU_CMD_REMU, 32'h1234_5678, 32'h0000_0abc);

        finish_run();
    end

endmodule

`default_nettype wire
